// ==== Makefile ====
SIM = obj_dir/Vtb_gateway_harness

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module tb_gateway_harness -f vlog.f

run: compile
	$(SIM) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== logic/gateway_harness.sv ====
`timescale 1ns/1ps
`include "harness_macros.svh"

module gateway_harness (
  input  logic                 blackparrot_clk,
  input  logic                 arst_n_i,

  // Serial tag stream
  input  logic                 tag_data_i,

  // Host request
  input  logic                 req_v_i,
  input  harness_pkg::col_t    req_col_i,
  input  harness_pkg::mem_op_e req_op_i,
  input  harness_pkg::addr_t   req_addr_i,
  input  harness_pkg::word_t   req_data_i,
  output logic                 req_ready_o,

  // Host response
  output logic                 resp_v_o,
  output harness_pkg::col_t    resp_col_o,
  output harness_pkg::word_t   resp_data_o,
  output logic                 resp_err_o,
  input  logic                 resp_ready_i,

  output logic                 run_o
);

  logic [`HARNESS_NUM_MEM-1:0] en_mask;
  logic                        run;

  mem_link_if links [`HARNESS_NUM_MEM] ();

  ////////////////////////////////////////////////////////////////////////////
  // Configuration, forward route, endpoints and response path

  tag_master tag_master_inst (
    .blackparrot_clk (blackparrot_clk),
    .arst_n_i        (arst_n_i),
    .tag_data_i      (tag_data_i),
    .en_mask_o       (en_mask),
    .run_o           (run)
  );

  req_router req_router_inst (
    .blackparrot_clk (blackparrot_clk),
    .arst_n_i        (arst_n_i),
    .run_i           (run),
    .req_v_i         (req_v_i),
    .req_col_i       (req_col_i),
    .req_op_i        (req_op_i),
    .req_addr_i      (req_addr_i),
    .req_data_i      (req_data_i),
    .req_ready_o     (req_ready_o),
    .links           (links)
  );

  for (genvar g = 0; g < `HARNESS_NUM_MEM; g++)
  begin : g_mem
    mem_endpoint mem_endpoint_inst (
      .blackparrot_clk (blackparrot_clk),
      .arst_n_i        (arst_n_i),
      .run_i           (run),
      .en_i            (en_mask[g]),
      .link            (links[g])
    );
  end

  resp_arbiter resp_arbiter_inst (
    .blackparrot_clk (blackparrot_clk),
    .arst_n_i        (arst_n_i),
    .run_i           (run),
    .resp_ready_i    (resp_ready_i),
    .links           (links),
    .resp_v_o        (resp_v_o),
    .resp_col_o      (resp_col_o),
    .resp_data_o     (resp_data_o),
    .resp_err_o      (resp_err_o)
  );

  assign run_o = run;

endmodule

// ==== logic/harness_macros.svh ====
`ifndef HARNESS_MACROS_SVH
`define HARNESS_MACROS_SVH

// Memory columns reachable from the host
`define HARNESS_NUM_MEM 4

// Word address inside one endpoint memory
`define HARNESS_ADDR_W 8

// Data word width on both request and response paths
`define HARNESS_DATA_W 32

// Destination column field of a host request
`define HARNESS_COL_W 2

// Request FIFO entries per endpoint
`define HARNESS_FIFO_DEPTH 4

// Serial tag frame fields
`define HARNESS_TAG_CLIENT_W 2
`define HARNESS_TAG_PAYLOAD_W 8

`endif

// ==== logic/harness_pkg.sv ====
`include "harness_macros.svh"

package harness_pkg;

  // Request operation carried on every link
  typedef enum logic
  {
    OP_LOAD  = 1'b0,
    OP_STORE = 1'b1
  } mem_op_e;

  // One data word
  typedef logic [`HARNESS_DATA_W-1:0] word_t;

  // Word address inside one endpoint
  typedef logic [`HARNESS_ADDR_W-1:0] addr_t;

  // Destination column
  typedef logic [`HARNESS_COL_W-1:0] col_t;

endpackage

// ==== logic/mem_endpoint.sv ====
`timescale 1ns/1ps
`include "harness_macros.svh"

module mem_endpoint (
  input  logic         blackparrot_clk,
  input  logic         arst_n_i,
  input  logic         run_i,
  input  logic         en_i,
  mem_link_if.endpoint link
);
  import harness_pkg::*;

  localparam int DEPTH     = `HARNESS_FIFO_DEPTH;
  localparam int PTR_W     = $clog2(DEPTH);
  localparam int CNT_W     = $clog2(DEPTH + 1);
  localparam int MEM_WORDS = 2 ** `HARNESS_ADDR_W;

  mem_op_e              fifo_op_q   [DEPTH];
  addr_t                fifo_addr_q [DEPTH];
  word_t                fifo_data_q [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     count_q;
  logic                 full;
  logic                 empty;
  logic                 push;
  logic                 pop;

  mem_op_e              head_op;
  addr_t                head_addr;
  word_t                head_data;

  word_t                mem_q [MEM_WORDS];
  logic [MEM_WORDS-1:0] written_q;
  logic                 mem_wr;
  word_t                rd_word;

  logic                 resp_v_q;
  word_t                resp_data_q;
  logic                 resp_err_q;

  ////////////////////////////////////////////////////////////////////////////
  // Request FIFO

  assign full           = (count_q == CNT_W'(DEPTH));
  assign empty          = (count_q == '0);
  assign link.req_ready = !full;
  assign push           = link.req_v && link.req_ready;

  // Head moves on when the response register is free or being taken
  assign pop = run_i && !empty && (!resp_v_q || link.resp_yumi);

  assign head_op   = fifo_op_q[rd_ptr_q];
  assign head_addr = fifo_addr_q[rd_ptr_q];
  assign head_data = fifo_data_q[rd_ptr_q];

  always_ff @(posedge blackparrot_clk)
  begin
    if (push)
    begin
      fifo_op_q[wr_ptr_q]   <= link.req_op;
      fifo_addr_q[wr_ptr_q] <= link.req_addr;
      fifo_data_q[wr_ptr_q] <= link.req_data;
    end
  end

  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (!run_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + PTR_W'(1);
      if (pop)
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + PTR_W'(1);
      if (push && !pop)
        count_q <= count_q + CNT_W'(1);
      else if (pop && !push)
        count_q <= count_q - CNT_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Word memory where unwritten words read as zero

  assign mem_wr  = pop && en_i && (head_op == OP_STORE);
  assign rd_word = written_q[head_addr] ? mem_q[head_addr] : '0;

  always_ff @(posedge blackparrot_clk)
  begin
    if (mem_wr)
      mem_q[head_addr] <= head_data;
  end

  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      written_q <= '0;
    else if (!run_i)
      written_q <= '0;
    else if (mem_wr)
      written_q[head_addr] <= 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response register

  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      resp_v_q <= 1'b0;
    else if (!run_i)
      resp_v_q <= 1'b0;
    else if (pop)
      resp_v_q <= 1'b1;
    else if (link.resp_yumi)
      resp_v_q <= 1'b0;
  end

  always_ff @(posedge blackparrot_clk)
  begin
    if (pop)
    begin
      // Disabled column answers with an error and no data
      if (!en_i)
      begin
        resp_data_q <= '0;
        resp_err_q  <= 1'b1;
      end
      else
      begin
        resp_data_q <= (head_op == OP_STORE) ? head_data : rd_word;
        resp_err_q  <= 1'b0;
      end
    end
  end

  assign link.resp_v    = resp_v_q;
  assign link.resp_data = resp_data_q;
  assign link.resp_err  = resp_err_q;

  // A stalled response holds until the arbiter takes it
  a_resp_held: assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    resp_v_q && !link.resp_yumi |=>
      resp_v_q && $stable(resp_data_q) && $stable(resp_err_q))
    else $error("held response changed before it was taken");

endmodule

// ==== logic/mem_link_if.sv ====
`timescale 1ns/1ps

interface mem_link_if;
  import harness_pkg::*;

  // Forward request from the router
  logic    req_v;
  mem_op_e req_op;
  addr_t   req_addr;
  word_t   req_data;
  logic    req_ready;

  // Reverse response toward the arbiter
  logic    resp_v;
  word_t   resp_data;
  logic    resp_err;
  logic    resp_yumi;

  modport router (
    output req_v, req_op, req_addr, req_data,
    input  req_ready
  );

  modport endpoint (
    input  req_v, req_op, req_addr, req_data, resp_yumi,
    output req_ready, resp_v, resp_data, resp_err
  );

  modport arbiter (
    input  resp_v, resp_data, resp_err,
    output resp_yumi
  );

endinterface

// ==== logic/req_router.sv ====
`timescale 1ns/1ps
`include "harness_macros.svh"

module req_router (
  input  logic                blackparrot_clk,
  input  logic                arst_n_i,
  input  logic                run_i,
  input  logic                req_v_i,
  input  harness_pkg::col_t   req_col_i,
  input  harness_pkg::mem_op_e req_op_i,
  input  harness_pkg::addr_t  req_addr_i,
  input  harness_pkg::word_t  req_data_i,
  output logic                req_ready_o,
  mem_link_if.router          links [`HARNESS_NUM_MEM]
);
  import harness_pkg::*;

  localparam int NUM = `HARNESS_NUM_MEM;

  logic [NUM-1:0] link_v;
  logic [NUM-1:0] link_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Column decode onto the links

  for (genvar g = 0; g < NUM; g++)
  begin : g_link
    // Valids stay low until the network is released
    assign link_v[g] = run_i && req_v_i && (req_col_i == col_t'(g));

    assign links[g].req_v    = link_v[g];
    assign links[g].req_op   = req_op_i;
    assign links[g].req_addr = req_addr_i;
    assign links[g].req_data = req_data_i;

    assign link_ready[g] = links[g].req_ready;
  end

  // Ready comes from the addressed column only
  assign req_ready_o = run_i && link_ready[req_col_i];

  // A host transfer is exactly one link push
  a_host_link_xfer: assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    (req_v_i && req_ready_o) == (|(link_v & link_ready)))
    else $error("host transfer and link push disagree");

endmodule

// ==== logic/resp_arbiter.sv ====
`timescale 1ns/1ps
`include "harness_macros.svh"

module resp_arbiter (
  input  logic               blackparrot_clk,
  input  logic               arst_n_i,
  input  logic               run_i,
  input  logic               resp_ready_i,
  mem_link_if.arbiter        links [`HARNESS_NUM_MEM],
  output logic               resp_v_o,
  output harness_pkg::col_t  resp_col_o,
  output harness_pkg::word_t resp_data_o,
  output logic               resp_err_o
);
  import harness_pkg::*;

  localparam int NUM = `HARNESS_NUM_MEM;

  logic [NUM-1:0] resp_v;
  word_t          resp_data [NUM];
  logic [NUM-1:0] resp_err;
  logic [NUM-1:0] yumi;
  col_t           ptr_q;
  col_t           grant_idx;
  logic           grant_v;
  logic           take;

  for (genvar g = 0; g < NUM; g++)
  begin : g_link
    assign resp_v[g]          = links[g].resp_v;
    assign resp_data[g]       = links[g].resp_data;
    assign resp_err[g]        = links[g].resp_err;
    assign yumi[g]            = take && (grant_idx == col_t'(g));
    assign links[g].resp_yumi = yumi[g];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Rotating priority search from ptr_q

  always_comb
  begin
    int idx;
    grant_v   = 1'b0;
    grant_idx = '0;
    for (int i = 0; i < NUM; i++)
    begin
      idx = (int'(ptr_q) + i) % NUM;
      if (!grant_v && resp_v[idx])
      begin
        grant_v   = 1'b1;
        grant_idx = col_t'(idx);
      end
    end
  end

  assign take = grant_v && resp_ready_i;

  // Served column drops to lowest priority
  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      ptr_q <= '0;
    else if (!run_i)
      ptr_q <= '0;
    else if (take)
      ptr_q <= (grant_idx == col_t'(NUM - 1)) ? '0 : grant_idx + col_t'(1);
  end

  assign resp_v_o    = grant_v;
  assign resp_col_o  = grant_idx;
  assign resp_data_o = resp_data[grant_idx];
  assign resp_err_o  = resp_err[grant_idx];

  // The link just served never wins again while another link waits
  a_served_last: assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    take |=> !(|(yumi & $past(yumi)) && |(resp_v & ~$past(yumi))))
    else $error("served link granted again ahead of a waiting link");

endmodule

// ==== logic/tag_master.sv ====
`timescale 1ns/1ps
`include "harness_macros.svh"

module tag_master (
  input  logic                        blackparrot_clk,
  input  logic                        arst_n_i,
  input  logic                        tag_data_i,
  output logic [`HARNESS_NUM_MEM-1:0] en_mask_o,
  output logic                        run_o
);

  localparam int CLIENT_W  = `HARNESS_TAG_CLIENT_W;
  localparam int PAYLOAD_W = `HARNESS_TAG_PAYLOAD_W;
  localparam int FRAME_W   = CLIENT_W + PAYLOAD_W;
  localparam int CNT_W     = $clog2(FRAME_W);

  localparam logic [CLIENT_W-1:0] CLIENT_MASK = CLIENT_W'(0);
  localparam logic [CLIENT_W-1:0] CLIENT_RUN  = CLIENT_W'(1);

  logic                        busy_q;
  logic [CNT_W-1:0]            bit_cnt_q;
  logic [FRAME_W-2:0]          shift_q;
  logic [FRAME_W-1:0]          frame;
  logic                        last_bit;
  logic [CLIENT_W-1:0]         client_id;
  logic [PAYLOAD_W-1:0]        payload;
  logic [`HARNESS_NUM_MEM-1:0] en_mask_q;
  logic                        run_q;

  // Frame is LSB first, so the current bit completes the top end
  assign frame     = {tag_data_i, shift_q};
  assign client_id = frame[CLIENT_W-1:0];
  assign payload   = frame[FRAME_W-1:CLIENT_W];
  assign last_bit  = busy_q && (bit_cnt_q == CNT_W'(FRAME_W - 1));

  always_ff @(posedge blackparrot_clk)
  begin
    if (busy_q)
      shift_q <= {tag_data_i, shift_q[FRAME_W-2:1]};
  end

  ////////////////////////////////////////////////////////////////////////////
  // Frame sequencing and client registers

  always_ff @(posedge blackparrot_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy_q    <= 1'b0;
      bit_cnt_q <= '0;
      en_mask_q <= '0;
      run_q     <= 1'b0;
    end
    else
    begin
      if (!busy_q)
      begin
        // Idle line is 0 and a 1 is the start bit
        if (tag_data_i)
        begin
          busy_q    <= 1'b1;
          bit_cnt_q <= '0;
        end
      end
      else if (last_bit)
        busy_q <= 1'b0;
      else
        bit_cnt_q <= bit_cnt_q + CNT_W'(1);

      if (last_bit)
      begin
        case (client_id)
          CLIENT_MASK: en_mask_q <= payload[`HARNESS_NUM_MEM-1:0];
          CLIENT_RUN:  if (|payload) run_q <= 1'b1;
          default:     ;
        endcase
      end
    end
  end

  assign en_mask_o = en_mask_q;
  assign run_o     = run_q;

  // One bit time per client and payload bit after the start bit
  a_frame_len: assert property (@(posedge blackparrot_clk) disable iff (!arst_n_i)
    $rose(busy_q) |-> ##(FRAME_W - 1) last_bit)
    else $error("tag frame length is wrong");

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic blackparrot_clk_o
);

  // 100 ns period starting low
  initial
  begin
    blackparrot_clk_o = 1'b0;
    forever #50 blackparrot_clk_o = ~blackparrot_clk_o;
  end

endmodule

// ==== test/tb_gateway_harness.sv ====
`timescale 1ns/1ps

module tb_gateway_harness;
  import harness_pkg::*;

  typedef struct packed
  {
    col_t    col;
    mem_op_e op;
    addr_t   addr;
    word_t   data;
    word_t   exp_data;
    logic    exp_err;
  } stim_t;

  typedef struct packed
  {
    col_t  col;
    word_t data;
    logic  err;
  } exp_t;

  localparam int NUM_STIM       = 25;
  localparam int SPLIT          = 21;
  localparam int FRAME_CYCLES   = 12;
  localparam int TIMEOUT_CYCLES = NUM_STIM * 20 + FRAME_CYCLES * 3 + 200;

  // Rows before SPLIT run with mask 4'b0111, later rows with all columns on
  localparam stim_t STIM [NUM_STIM] = '{
    // col   op        addr   data           exp_data       err
    '{2'd0, OP_STORE, 8'h10, 32'ha0a0_0001, 32'ha0a0_0001, 1'b0},
    '{2'd1, OP_STORE, 8'h20, 32'hb1b1_0002, 32'hb1b1_0002, 1'b0},
    '{2'd2, OP_STORE, 8'h30, 32'hc2c2_0003, 32'hc2c2_0003, 1'b0},
    '{2'd0, OP_LOAD,  8'h10, 32'h0000_0000, 32'ha0a0_0001, 1'b0},
    '{2'd1, OP_LOAD,  8'h20, 32'h0000_0000, 32'hb1b1_0002, 1'b0},
    '{2'd2, OP_LOAD,  8'h30, 32'h0000_0000, 32'hc2c2_0003, 1'b0},
    '{2'd0, OP_LOAD,  8'h11, 32'h0000_0000, 32'h0000_0000, 1'b0},
    // Column 3 is masked off
    '{2'd3, OP_STORE, 8'h05, 32'hdead_beef, 32'h0000_0000, 1'b1},
    '{2'd3, OP_LOAD,  8'h05, 32'h0000_0000, 32'h0000_0000, 1'b1},
    // Burst to column 0 deeper than its FIFO
    '{2'd0, OP_STORE, 8'h00, 32'h1111_0000, 32'h1111_0000, 1'b0},
    '{2'd0, OP_STORE, 8'h01, 32'h2222_0001, 32'h2222_0001, 1'b0},
    '{2'd0, OP_STORE, 8'h02, 32'h3333_0002, 32'h3333_0002, 1'b0},
    '{2'd0, OP_STORE, 8'h03, 32'h4444_0003, 32'h4444_0003, 1'b0},
    '{2'd0, OP_STORE, 8'h00, 32'h5555_0004, 32'h5555_0004, 1'b0},
    '{2'd0, OP_LOAD,  8'h00, 32'h0000_0000, 32'h5555_0004, 1'b0},
    '{2'd0, OP_LOAD,  8'h01, 32'h0000_0000, 32'h2222_0001, 1'b0},
    '{2'd0, OP_LOAD,  8'h02, 32'h0000_0000, 32'h3333_0002, 1'b0},
    '{2'd0, OP_LOAD,  8'h03, 32'h0000_0000, 32'h4444_0003, 1'b0},
    '{2'd1, OP_LOAD,  8'h20, 32'h0000_0000, 32'hb1b1_0002, 1'b0},
    '{2'd2, OP_STORE, 8'h30, 32'h0bad_f00d, 32'h0bad_f00d, 1'b0},
    '{2'd2, OP_LOAD,  8'h30, 32'h0000_0000, 32'h0bad_f00d, 1'b0},
    // Column 3 enabled again with its memory never written
    '{2'd3, OP_LOAD,  8'h05, 32'h0000_0000, 32'h0000_0000, 1'b0},
    '{2'd3, OP_STORE, 8'h06, 32'h7777_0006, 32'h7777_0006, 1'b0},
    '{2'd3, OP_LOAD,  8'h06, 32'h0000_0000, 32'h7777_0006, 1'b0},
    '{2'd0, OP_LOAD,  8'h10, 32'h0000_0000, 32'ha0a0_0001, 1'b0}
  };

  logic    blackparrot_clk;
  logic    arst_n_i;
  logic    tag_data_i;
  logic    req_v_i;
  col_t    req_col_i;
  mem_op_e req_op_i;
  addr_t   req_addr_i;
  word_t   req_data_i;
  logic    req_ready_o;
  logic    resp_v_o;
  col_t    resp_col_o;
  word_t   resp_data_o;
  logic    resp_err_o;
  logic    resp_ready_i;
  logic    run_o;

  exp_t    exp_q [$];
  int      cycle_count;
  logic    released;

  tb_clock_gen clock_gen_inst (
    .blackparrot_clk_o (blackparrot_clk)
  );

  gateway_harness gateway_harness_inst (
    .blackparrot_clk (blackparrot_clk),
    .arst_n_i        (arst_n_i),
    .tag_data_i      (tag_data_i),
    .req_v_i         (req_v_i),
    .req_col_i       (req_col_i),
    .req_op_i        (req_op_i),
    .req_addr_i      (req_addr_i),
    .req_data_i      (req_data_i),
    .req_ready_o     (req_ready_o),
    .resp_v_o        (resp_v_o),
    .resp_col_o      (resp_col_o),
    .resp_data_o     (resp_data_o),
    .resp_err_o      (resp_err_o),
    .resp_ready_i    (resp_ready_i),
    .run_o           (run_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("test failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Advance to the next drive point and draw resp_ready_i low about 1 in 4
  task automatic step();
    @(posedge blackparrot_clk);
    #10;
    resp_ready_i = ($urandom % 4) != 0;
  endtask

  // Start bit, client id and payload LSB first followed by one idle cycle
  task automatic send_tag(input logic [1:0] client, input logic [7:0] payload);
    logic [10:0] frame;
    frame = {payload, client, 1'b1};
    for (int i = 0; i < 11; i++)
    begin
      tag_data_i = frame[i];
      step();
    end
    tag_data_i = 1'b0;
    step();
  endtask

  // Ready seen at the falling edge means a transfer on the next rising edge
  task automatic send_req(input stim_t s);
    logic accepted;
    accepted   = 1'b0;
    req_v_i    = 1'b1;
    req_col_i  = s.col;
    req_op_i   = s.op;
    req_addr_i = s.addr;
    req_data_i = s.data;
    while (!accepted)
    begin
      @(negedge blackparrot_clk);
      if (req_ready_o)
      begin
        accepted = 1'b1;
        exp_q.push_back(exp_t'{s.col, s.exp_data, s.exp_err});
      end
      step();
    end
    req_v_i = 1'b0;
  endtask

  // Outstanding responses drain first and the port must then stay quiet
  task automatic wait_drain();
    while (exp_q.size() != 0)
      step();
    repeat (4)
    begin
      @(negedge blackparrot_clk);
      check_value(32'(resp_v_o), 32'd0, "resp_v_o with nothing outstanding");
      step();
    end
  endtask

  // Oldest outstanding entry of the same column is the one due
  task automatic watch_responses();
    int idx;
    forever
    begin
      @(negedge blackparrot_clk);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
        $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $fatal(1, "Timeout");
      end
      if (released)
        check_value(32'(run_o), 32'd1, "run_o after release");
      if (resp_v_o && resp_ready_i)
      begin
        idx = -1;
        for (int i = 0; i < exp_q.size(); i++)
        begin
          if (idx < 0 && exp_q[i].col == resp_col_o)
            idx = i;
        end
        if (idx < 0)
        begin
          $display("Response from column %0d arrived with no request outstanding", resp_col_o);
          $display("test failed");
          $fatal(1, "Unexpected response");
        end
        else
        begin
          check_value(resp_data_o, exp_q[idx].data,
                      $sformatf("resp_data_o of column %0d", resp_col_o));
          check_value(32'(resp_err_o), 32'(exp_q[idx].err),
                      $sformatf("resp_err_o of column %0d", resp_col_o));
          exp_q.delete(idx);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence

  initial
  begin
    void'($urandom(32'hc00e_59e1));
    arst_n_i     = 1'b0;
    tag_data_i   = 1'b0;
    req_v_i      = 1'b0;
    req_col_i    = '0;
    req_op_i     = OP_LOAD;
    req_addr_i   = '0;
    req_data_i   = '0;
    resp_ready_i = 1'b0;
    released     = 1'b0;
    cycle_count  = 0;

    fork
      watch_responses();
    join_none

    repeat (10) step();
    arst_n_i = 1'b1;

    // Network is held until the release frame
    req_v_i    = 1'b1;
    req_col_i  = 2'd1;
    req_op_i   = OP_STORE;
    req_addr_i = 8'h20;
    req_data_i = 32'h5a5a_5a5a;
    repeat (4)
    begin
      @(negedge blackparrot_clk);
      check_value(32'(req_ready_o), 32'd0, "req_ready_o before release");
      check_value(32'(run_o), 32'd0, "run_o before release");
      check_value(32'(resp_v_o), 32'd0, "resp_v_o before release");
      step();
    end
    req_v_i = 1'b0;

    send_tag(2'd0, 8'h07);
    check_value(32'(run_o), 32'd0, "run_o after mask frame");
    send_tag(2'd1, 8'h01);
    check_value(32'(run_o), 32'd1, "run_o after release frame");
    released = 1'b1;

    for (int i = 0; i < SPLIT; i++)
      send_req(STIM[i]);
    wait_drain();

    send_tag(2'd0, 8'h0f);
    for (int i = SPLIT; i < NUM_STIM; i++)
      send_req(STIM[i]);
    wait_drain();

    $display("test passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/harness_pkg.sv
logic/mem_link_if.sv
logic/tag_master.sv
logic/req_router.sv
logic/mem_endpoint.sv
logic/resp_arbiter.sv
logic/gateway_harness.sv
test/tb_clock_gen.sv
test/tb_gateway_harness.sv
